/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_trs_io_card
FILELIST  := trs_io_card.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/card_ram.sv */
`timescale 1ns/1ps

module card_ram (
  input  logic                           clk,
  input  trs_bus_pkg::ram_req_t          a_req,
  input  trs_bus_pkg::ram_req_t          b_req,
  output logic [trs_bus_pkg::data_w-1:0] a_rdata,
  output logic [trs_bus_pkg::data_w-1:0] b_rdata
);

  // upper 32K of the z80 map
  logic [trs_bus_pkg::data_w-1:0] mem [2**trs_bus_pkg::ram_addr_w];
  logic [trs_bus_pkg::data_w-1:0] a_q;   // array read stage
  logic [trs_bus_pkg::data_w-1:0] b_q;

  // both ports write first, b wins a same-address write
  always_ff @(posedge clk) begin
    if (a_req.valid) begin
      if (a_req.we) begin
        mem[a_req.addr] <= a_req.wdata;
        a_q             <= a_req.wdata;
      end else begin
        a_q <= mem[a_req.addr];
      end
    end
    if (b_req.valid) begin
      if (b_req.we) begin
        mem[b_req.addr] <= b_req.wdata;
        b_q             <= b_req.wdata;
      end else begin
        b_q <= mem[b_req.addr];
      end
    end
    a_rdata <= a_q;   // output regs, second read cycle
    b_rdata <= b_q;
  end

endmodule

/* hdl/esp_cmd_parser.sv */
`timescale 1ns/1ps

module esp_cmd_parser (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rx_valid,
  input  logic                  frame_start,
  input  logic [7:0]            rx_byte,
  output logic [7:0]            tx_byte,
  output logic                  tx_load,
  output trs_bus_pkg::ram_req_t ram_req,
  input  logic [7:0]            ram_rdata,
  input  logic [7:0]            out_byte,
  output logic [7:0]            in_byte,
  output logic                  in_byte_load
);

  typedef enum logic [1:0] {
    st_idle   = 2'b01,   // waiting for a command byte
    st_params = 2'b10    // collecting parameter bytes
  } state_t;

  state_t          state;
  logic [7:0]      cmd_q;
  logic [1:0]      param_cnt;   // bytes still to come
  logic            param_idx;   // next store slot
  logic [1:0][7:0] params;      // addr lo, addr hi
  logic            skip_q;      // dummy byte of a reply is next
  logic            take_cmd;
  logic            last_param;
  logic            req_valid_q;
  logic            req_we_q;
  logic [trs_bus_pkg::ram_addr_w-1:0] req_addr_q;
  logic [7:0]      req_wdata_q;
  logic [1:0]      rd_pend;     // peek data in flight
  logic [7:0]      reply_q;
  logic            reply_load_q;

  assign take_cmd   = rx_valid && state == st_idle && !skip_q;
  assign last_param = rx_valid && state == st_params && param_cnt == 2'd1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      param_cnt    <= '0;
      param_idx    <= 1'b0;
      skip_q       <= 1'b0;
      req_valid_q  <= 1'b0;
      rd_pend      <= '0;
      reply_load_q <= 1'b0;
      in_byte_load <= 1'b0;
    end else begin
      req_valid_q  <= 1'b0;
      reply_load_q <= 1'b0;
      in_byte_load <= 1'b0;
      rd_pend      <= {rd_pend[0], req_valid_q & ~req_we_q};
      if (frame_start) begin
        state  <= st_idle;   // new message
        skip_q <= 1'b0;
      end else if (rx_valid) begin
        case (state)
          st_idle: begin
            skip_q    <= 1'b0;
            param_idx <= 1'b0;
            if (!skip_q) begin
              case (rx_byte)
                esp_cmd_pkg::cmd_get_cookie,
                esp_cmd_pkg::cmd_get_version,
                esp_cmd_pkg::cmd_dbus_read: begin
                  reply_load_q <= 1'b1;   // answer now
                  skip_q       <= 1'b1;
                end
                esp_cmd_pkg::cmd_bram_poke: begin
                  param_cnt <= esp_cmd_pkg::poke_param_cnt;
                  state     <= st_params;
                end
                esp_cmd_pkg::cmd_bram_peek: begin
                  param_cnt <= esp_cmd_pkg::peek_param_cnt;
                  state     <= st_params;
                end
                esp_cmd_pkg::cmd_dbus_write: begin
                  param_cnt <= esp_cmd_pkg::dbus_write_param_cnt;
                  state     <= st_params;
                end
                default: ;   // unknown code dropped
              endcase
            end
          end
          st_params: begin
            if (param_cnt == 2'd1) begin
              state <= st_idle;
              case (cmd_q)
                esp_cmd_pkg::cmd_bram_poke:  req_valid_q <= 1'b1;
                esp_cmd_pkg::cmd_bram_peek: begin
                  req_valid_q <= 1'b1;
                  skip_q      <= 1'b1;   // reply rides on the dummy byte
                end
                esp_cmd_pkg::cmd_dbus_write: in_byte_load <= 1'b1;
                default: ;
              endcase
            end else begin
              param_cnt <= param_cnt - 2'd1;
              param_idx <= 1'b1;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // payload, captured as bytes arrive
  always_ff @(posedge clk) begin
    if (take_cmd) begin
      cmd_q <= rx_byte;
      case (rx_byte)
        esp_cmd_pkg::cmd_get_cookie:  reply_q <= esp_cmd_pkg::cookie;
        esp_cmd_pkg::cmd_get_version:
          reply_q <= {esp_cmd_pkg::version_major, esp_cmd_pkg::version_minor};
        default:                      reply_q <= out_byte;   // dbus_read
      endcase
    end
    if (rx_valid && state == st_params && param_cnt != 2'd1) params[param_idx] <= rx_byte;
    if (last_param) begin
      req_we_q    <= (cmd_q == esp_cmd_pkg::cmd_bram_poke);
      req_addr_q  <= (cmd_q == esp_cmd_pkg::cmd_bram_poke) ? {params[1][6:0], params[0]}
                                                            : {rx_byte[6:0], params[0]};
      req_wdata_q <= rx_byte;
      in_byte     <= rx_byte;
    end
  end

  assign ram_req = '{addr: req_addr_q, wdata: req_wdata_q, we: req_we_q, valid: req_valid_q};

  // peek data bypasses reply_q to meet the next sck fall
  assign tx_load = rd_pend[1] | reply_load_q;
  assign tx_byte = rd_pend[1] ? ram_rdata : reply_q;

  assert property (@(posedge clk) disable iff (rst) state inside {st_idle, st_params})
    else $error("parser state left its legal encoding");

endmodule

/* hdl/esp_cmd_pkg.sv */
package esp_cmd_pkg;

  // spi command codes, first byte of every message
  localparam logic [7:0] cmd_get_cookie  = 8'd0;
  localparam logic [7:0] cmd_bram_poke   = 8'd1;
  localparam logic [7:0] cmd_bram_peek   = 8'd2;
  localparam logic [7:0] cmd_dbus_read   = 8'd3;
  localparam logic [7:0] cmd_dbus_write  = 8'd4;
  localparam logic [7:0] cmd_get_version = 8'd15;

  // parameter bytes after the command byte
  localparam logic [1:0] poke_param_cnt       = 2'd3;  // addr lo, addr hi, data
  localparam logic [1:0] peek_param_cnt       = 2'd2;  // addr lo, addr hi
  localparam logic [1:0] dbus_write_param_cnt = 2'd1;  // data

  // identification
  localparam logic [7:0] cookie        = 8'haf;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  // request code shown to the esp on ESP_S
  typedef logic [2:0] esp_s_t;

  localparam esp_s_t esp_io_in  = 3'd0;  // z80 IN from port 31
  localparam esp_s_t esp_io_out = 3'd1;  // z80 OUT to port 31

endpackage

/* hdl/spi_byte_slave.sv */
`timescale 1ns/1ps

module spi_byte_slave (
  input  logic       clk,
  input  logic       rst,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic [7:0] tx_byte,
  input  logic       tx_load,
  output logic       miso,
  output logic       rx_valid,
  output logic       frame_start,
  output logic [7:0] rx_byte
);

  logic [2:0] sck_s;      // 3-flop sync chains
  logic [2:0] cs_s;
  logic [2:0] mosi_s;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;    // bits of the current byte
  logic [6:0] rx_shift;
  logic [7:0] tx_buf;     // reply waiting for the next frame
  logic       tx_pend;
  logic [7:0] tx_shift;   // msb is on miso

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_s  <= '0;
      cs_s   <= '1;   // deselected
      mosi_s <= '0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs_n};
      mosi_s <= {mosi_s[1:0], mosi};
    end
  end

  assign sck_rise    = (sck_s[2:1] == 2'b01);
  assign sck_fall    = (sck_s[2:1] == 2'b10);
  assign cs_active   = ~cs_s[1];
  assign frame_start = cs_s[2] & ~cs_s[1];   // cs falling edge

  // mode 0, sample on rise, msb first
  always_ff @(posedge clk) begin
    if (rst || !cs_active) bit_cnt <= '0;
    else if (sck_rise)     bit_cnt <= bit_cnt + 3'd1;
  end

  always_ff @(posedge clk) begin
    if (sck_rise) rx_shift <= {rx_shift[5:0], mosi_s[2]};
    if (tx_load)  tx_buf   <= tx_byte;
  end

  assign rx_byte  = {rx_shift, mosi_s[2]};
  assign rx_valid = cs_active & sck_rise & (bit_cnt == 3'd7);

  // last fall of a byte puts the msb of the next one on miso
  always_ff @(posedge clk) begin
    if (rst || frame_start) begin
      tx_pend  <= 1'b0;
      tx_shift <= '0;
    end else if (cs_active && sck_fall && bit_cnt == 3'd0) begin
      tx_shift <= tx_load ? tx_byte : (tx_pend ? tx_buf : 8'h00);  // zeros if nothing loaded
      tx_pend  <= 1'b0;
    end else begin
      if (cs_active && sck_fall) tx_shift <= {tx_shift[6:0], 1'b0};
      if (tx_load)               tx_pend  <= 1'b1;
    end
  end

  assign miso = cs_active & tx_shift[7];

  // a byte is only complete with cs held low across the sync chain
  assert property (@(posedge clk) disable iff (rst) rx_valid |-> !cs_s[2] && !cs_s[1])
    else $error("spi byte received with cs inactive");

endmodule

/* hdl/trs_bus_pkg.sv */
package trs_bus_pkg;

  // z80 side geometry
  localparam int addr_w         = 16;
  localparam int data_w         = 8;
  localparam int ram_addr_w     = 15;   // 32K card ram
  localparam int ram_region_bit = 15;   // a15 high selects the card ram

  // trs-io port, matched against the low address byte only
  localparam logic [7:0] trs_io_port = 8'd31;

  // z80 bus at the card edge
  // strobes are active low as on the real edge connector
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              rd_n;    // memory read
    logic              wr_n;    // memory write
    logic              in_n;    // port read
    logic              out_n;   // port write
  } z80_bus_t;

  // single ram port access
  typedef struct packed {
    logic [ram_addr_w-1:0] addr;
    logic [data_w-1:0]     wdata;
    logic                  we;      // low for a read
    logic                  valid;   // one cycle per access
  } ram_req_t;

endpackage

/* hdl/trs_io_card.sv */
`timescale 1ns/1ps

module trs_io_card (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sck,
  input  logic                  cs_n,
  input  logic                  mosi,
  output logic                  miso,
  input  trs_bus_pkg::z80_bus_t bus,
  input  logic [7:0]            z80_d_in,
  output logic [7:0]            z80_d_out,
  output logic                  z80_d_oe,
  output logic                  esp_req,
  output logic                  z80_wait,
  output esp_cmd_pkg::esp_s_t   esp_s,
  input  logic                  esp_done
);

  logic [7:0]            rx_byte;
  logic                  rx_valid;
  logic                  frame_start;
  logic [7:0]            tx_byte;
  logic                  tx_load;
  trs_bus_pkg::ram_req_t a_req;     // z80 side
  trs_bus_pkg::ram_req_t b_req;     // esp side
  logic [7:0]            a_rdata;
  logic [7:0]            b_rdata;
  logic [7:0]            out_byte;  // last OUT to port 31
  logic [7:0]            in_byte;   // next IN from port 31
  logic                  in_byte_load;

  spi_byte_slave u_spi (.clk, .rst, .sck, .cs_n, .mosi, .tx_byte, .tx_load, .miso,
                        .rx_valid, .frame_start, .rx_byte);

  esp_cmd_parser u_parser (.clk, .rst, .rx_valid, .frame_start, .rx_byte, .tx_byte,
                           .tx_load, .ram_req(b_req), .ram_rdata(b_rdata), .out_byte,
                           .in_byte, .in_byte_load);

  card_ram u_ram (.clk, .a_req, .b_req, .a_rdata, .b_rdata);

  z80_bus_port u_bus (.clk, .rst, .bus, .z80_d_in, .z80_d_out, .z80_d_oe,
                      .ram_req(a_req), .ram_rdata(a_rdata), .esp_req, .z80_wait,
                      .esp_s, .esp_done, .out_byte, .in_byte, .in_byte_load);

endmodule

/* hdl/z80_bus_port.sv */
`timescale 1ns/1ps

module z80_bus_port (
  input  logic                  clk,
  input  logic                  rst,
  input  trs_bus_pkg::z80_bus_t bus,
  input  logic [7:0]            z80_d_in,
  output logic [7:0]            z80_d_out,
  output logic                  z80_d_oe,
  output trs_bus_pkg::ram_req_t ram_req,
  input  logic [7:0]            ram_rdata,
  output logic                  esp_req,
  output logic                  z80_wait,
  output esp_cmd_pkg::esp_s_t   esp_s,
  input  logic                  esp_done,
  output logic [7:0]            out_byte,
  input  logic [7:0]            in_byte,
  input  logic                  in_byte_load
);

  trs_bus_pkg::z80_bus_t bus_m;   // first sync stage
  trs_bus_pkg::z80_bus_t bus_s;   // second sync stage
  logic [3:0] strb_q;             // previous rd, wr, in, out
  logic [1:0] done_s;
  logic       done_sync;
  logic       rd_fall;
  logic       wr_fall;
  logic       in_fall;
  logic       out_fall;
  logic       ram_hit;
  logic       port_hit;
  logic       io_out_hit;
  logic       io_hit;
  logic       start_req;
  logic       pend_q;             // access seen, esp still busy
  logic       req_valid_q;
  logic       req_we_q;
  logic [trs_bus_pkg::ram_addr_w-1:0] req_addr_q;
  logic [7:0] req_wdata_q;
  logic [7:0] in_byte_q;          // answer for the next IN

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_m  <= '1;   // strobes idle high
      bus_s  <= '1;
      strb_q <= '1;
      done_s <= '0;
    end else begin
      bus_m  <= bus;
      bus_s  <= bus_m;
      strb_q <= {bus_s.rd_n, bus_s.wr_n, bus_s.in_n, bus_s.out_n};
      done_s <= {done_s[0], esp_done};
    end
  end

  assign done_sync  = done_s[1];
  assign rd_fall    = strb_q[3] & ~bus_s.rd_n;
  assign wr_fall    = strb_q[2] & ~bus_s.wr_n;
  assign in_fall    = strb_q[1] & ~bus_s.in_n;
  assign out_fall   = strb_q[0] & ~bus_s.out_n;
  assign ram_hit    = bus_s.addr[trs_bus_pkg::ram_region_bit];
  assign port_hit   = (bus_s.addr[7:0] == trs_bus_pkg::trs_io_port);
  assign io_out_hit = out_fall & port_hit;
  assign io_hit     = (in_fall | out_fall) & port_hit;
  assign start_req  = (io_hit | pend_q) & ~done_sync & ~esp_req;

  // ram port a, one request per strobe
  always_ff @(posedge clk) begin
    if (rst) req_valid_q <= 1'b0;
    else     req_valid_q <= (rd_fall | wr_fall) & ram_hit;
  end

  always_ff @(posedge clk) begin
    if (rd_fall || wr_fall) begin
      req_we_q    <= wr_fall;
      req_addr_q  <= bus_s.addr[trs_bus_pkg::ram_addr_w-1:0];
      req_wdata_q <= z80_d_in;   // stable while wr_n low
    end
    if (io_out_hit)   out_byte  <= z80_d_in;
    if (in_byte_load) in_byte_q <= in_byte;
  end

  assign ram_req = '{addr: req_addr_q, wdata: req_wdata_q, we: req_we_q, valid: req_valid_q};

  // four-phase req/ack with the esp, WAIT follows req
  always_ff @(posedge clk) begin
    if (rst) begin
      esp_req  <= 1'b0;
      z80_wait <= 1'b0;
      pend_q   <= 1'b0;
      esp_s    <= esp_cmd_pkg::esp_io_in;
    end else begin
      if (start_req) begin
        esp_req  <= 1'b1;
        z80_wait <= 1'b1;
        pend_q   <= 1'b0;
      end else if (io_hit) begin
        z80_wait <= 1'b1;   // hold z80 until done drops
        pend_q   <= 1'b1;
      end else if (esp_req && done_sync) begin
        esp_req  <= 1'b0;
        z80_wait <= 1'b0;
      end
      if (io_hit) esp_s <= io_out_hit ? esp_cmd_pkg::esp_io_out : esp_cmd_pkg::esp_io_in;
    end
  end

  // raw strobes so the driver turns off with the z80
  assign z80_d_oe  = (~bus.rd_n & bus.addr[trs_bus_pkg::ram_region_bit]) |
                     (~bus.in_n & (bus.addr[7:0] == trs_bus_pkg::trs_io_port));
  assign z80_d_out = ~bus.in_n ? in_byte_q : ram_rdata;

  // esp must have finished the previous handshake
  assert property (@(posedge clk) disable iff (rst) $rose(esp_req) |-> !$past(done_sync))
    else $error("esp_req raised while esp_done still high");

endmodule

/* trs_io_card.f */
hdl/trs_bus_pkg.sv
hdl/esp_cmd_pkg.sv
hdl/spi_byte_slave.sv
hdl/esp_cmd_parser.sv
hdl/card_ram.sv
hdl/z80_bus_port.sv
hdl/trs_io_card.sv
verif/tb_clock_gen.sv
verif/tb_trs_io_card.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;   // released on the drive point
  end

endmodule

/* verif/tb_trs_io_card.sv */
`timescale 1ns/1ps

module tb_trs_io_card;

  logic                  clk;
  logic                  rst;
  logic                  sck;
  logic                  cs_n;
  logic                  mosi;
  logic                  miso;
  trs_bus_pkg::z80_bus_t bus;
  logic [7:0]            z80_d_in;
  logic [7:0]            z80_d_out;
  logic                  z80_d_oe;
  logic                  esp_req;
  logic                  z80_wait;
  esp_cmd_pkg::esp_s_t   esp_s;
  logic                  esp_done;   // esp model below

  tb_clock_gen u_clk (.clk, .rst);

  trs_io_card uut (
    .clk, .rst, .sck, .cs_n, .mosi, .miso, .bus, .z80_d_in, .z80_d_out, .z80_d_oe,
    .esp_req, .z80_wait, .esp_s, .esp_done
  );

  task automatic stop_run(input bit wrong_value, input string msg);
    if (wrong_value) $display("[ERROR] %0d ns: %s", $time, msg);
    else             $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  // memory below 32K is not ours
  assert property (@(posedge clk) disable iff (rst)
                   (!bus.rd_n && bus.in_n && !bus.addr[15]) |-> !z80_d_oe)
    else stop_run(1'b1, "z80_d_oe high on a read outside the card ram");

  assert property (@(posedge clk) disable iff (rst) esp_req |-> z80_wait)
    else stop_run(1'b1, "wait low while esp_req is open");

  task automatic clocks(input int n);
    repeat (n) @(posedge clk);
    #1;   // drive point
  endtask

  // mode 0, msb first, half period of 8 clocks
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      clocks(8);
      sck   = 1'b1;
      rx[i] = miso;   // sampled on the rise
      clocks(8);
      sck = 1'b0;
    end
  endtask

  // one cs frame, last holds what came back during the final byte
  task automatic spi_msg(input int len, input logic [7:0] b0, b1, b2, b3,
                         output logic [7:0] last);
    logic [7:0] msg [4];
    msg  = '{b0, b1, b2, b3};
    cs_n = 1'b0;
    clocks(8);
    for (int k = 0; k < len; k++) spi_byte(msg[k], last);
    clocks(8);
    cs_n = 1'b1;
    clocks(8);
  endtask

  task automatic wait_esp_req(input esp_cmd_pkg::esp_s_t exp_s);
    int n = 0;
    while (!esp_req) begin
      if (n == 32) stop_run(1'b0, "esp_req never rose after a port 31 access");
      clocks(1);
      n++;
    end
    assert (esp_s == exp_s)
      else stop_run(1'b1, $sformatf("esp_s is %0d, expected %0d", esp_s, exp_s));
  endtask

  // esp side of the handshake, req and wait must clear within 3 cycles
  task automatic ack_esp();
    int n = 0;
    esp_done = 1'b1;
    while ((esp_req || z80_wait) && n < 3) begin
      clocks(1);
      n++;
    end
    assert (!esp_req && !z80_wait)
      else stop_run(1'b1, "esp_req or wait still high 3 cycles after esp_done");
    esp_done = 1'b0;
  endtask

  task automatic z80_mem_read(input logic [15:0] addr, input logic [7:0] exp);
    bus.addr = addr;
    bus.rd_n = 1'b0;
    clocks(5);   // 2 sync, request, 2 ram stages
    assert (z80_d_oe && z80_d_out == exp)
      else stop_run(1'b1, $sformatf("read %h gave %h oe %b, expected %h",
                                    addr, z80_d_out, z80_d_oe, exp));
    bus.rd_n = 1'b1;
    clocks(2);
  endtask

  task automatic z80_mem_write(input logic [15:0] addr, input logic [7:0] data);
    bus.addr = addr;
    z80_d_in = data;
    bus.wr_n = 1'b0;
    clocks(4);   // ram written on the third cycle
    bus.wr_n = 1'b1;
    clocks(2);
  endtask

  task automatic z80_port(input bit is_out, input logic [7:0] data);
    bus.addr  = {8'($urandom), 8'd31};   // upper byte is don't care
    z80_d_in  = data;
    bus.out_n = ~is_out;
    bus.in_n  = is_out;
    wait_esp_req(is_out ? esp_cmd_pkg::esp_io_out : esp_cmd_pkg::esp_io_in);
    if (!is_out) begin
      assert (z80_d_oe && z80_d_out == data)
        else stop_run(1'b1, $sformatf("port 31 IN shows %h oe %b, expected %h",
                                      z80_d_out, z80_d_oe, data));
    end
    ack_esp();
    bus.out_n = 1'b1;   // z80 finishes once wait is gone
    bus.in_n  = 1'b1;
    clocks(4);          // esp_done low through the sync
  endtask

  initial begin
    logic [7:0]  rdata;
    logic [7:0]  data;
    logic [14:0] ram_a;
    int          n;
    void'($urandom(32'h9df06df2));
    sck      = 1'b0;
    cs_n     = 1'b1;
    mosi     = 1'b0;
    bus      = '{addr: 16'h0000, rd_n: 1'b1, wr_n: 1'b1, in_n: 1'b1, out_n: 1'b1};
    z80_d_in = 8'h00;
    esp_done = 1'b0;
    n        = 0;
    while (rst !== 1'b0) begin   // also covers rst still unknown at time 0
      if (n == 20) stop_run(1'b0, "reset was never released");
      @(posedge clk);
      n++;
    end
    clocks(1);
    assert (!esp_req && !z80_wait && !z80_d_oe && !miso && esp_s == 3'd0)
      else stop_run(1'b1, "outputs not idle after reset");
    spi_msg(2, esp_cmd_pkg::cmd_get_cookie, 8'h00, 8'h00, 8'h00, rdata);
    assert (rdata == 8'haf) else stop_run(1'b1, $sformatf("cookie %h", rdata));
    spi_msg(2, esp_cmd_pkg::cmd_get_version, 8'h00, 8'h00, 8'h00, rdata);
    assert (rdata == 8'h03) else stop_run(1'b1, $sformatf("version %h", rdata));

    // esp poke, esp peek, z80 read of the same byte
    ram_a = 15'($urandom);
    data  = 8'($urandom);
    spi_msg(4, esp_cmd_pkg::cmd_bram_poke, ram_a[7:0], {1'b0, ram_a[14:8]}, data, rdata);
    spi_msg(4, esp_cmd_pkg::cmd_bram_peek, ram_a[7:0], {1'b0, ram_a[14:8]}, 8'h00, rdata);
    assert (rdata == data)
      else stop_run(1'b1, $sformatf("peek %h gave %h, expected %h", ram_a, rdata, data));
    z80_mem_read({1'b1, ram_a}, data);

    // z80 write seen by the esp
    ram_a = 15'($urandom);
    data  = 8'($urandom);
    z80_mem_write({1'b1, ram_a}, data);
    spi_msg(4, esp_cmd_pkg::cmd_bram_peek, ram_a[7:0], {1'b0, ram_a[14:8]}, 8'h00, rdata);
    assert (rdata == data)
      else stop_run(1'b1, $sformatf("peek %h gave %h, expected %h", ram_a, rdata, data));
    bus.addr = {1'b0, 15'($urandom)};   // below 32K
    bus.rd_n = 1'b0;
    clocks(6);
    bus.rd_n = 1'b1;
    clocks(2);

    // OUT to port 31, then dbus_read
    data = 8'($urandom);
    z80_port(1'b1, data);
    spi_msg(2, esp_cmd_pkg::cmd_dbus_read, 8'h00, 8'h00, 8'h00, rdata);
    assert (rdata == data)
      else stop_run(1'b1, $sformatf("dbus_read gave %h, expected %h", rdata, data));

    // dbus_write, then IN from port 31
    data = 8'($urandom);
    spi_msg(2, esp_cmd_pkg::cmd_dbus_write, data, 8'h00, 8'h00, rdata);
    z80_port(1'b0, data);

    $display("** PASS **");
    $finish;
  end

endmodule
